// ==== lane.f ====
+incdir+tb
logic/lane_cfg_pkg.sv
logic/lane_op_pkg.sv
logic/lane_ifs.sv
logic/lane_sequencer.sv
logic/vector_regfile.sv
logic/operand_queue.sv
logic/vector_alu.sv
logic/lane.sv
tb/tb_lane.sv

// ==== logic/lane.sv ====
// Vector lane top level
`default_nettype none

module lane (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // Instruction handshake
  input  wire                      insn_req_i,
  input  lane_op_pkg::alu_op_e     insn_op_i,
  input  lane_op_pkg::vew_e        insn_vew_i,
  input  lane_cfg_pkg::vreg_idx_t  insn_vd_i,
  input  lane_cfg_pkg::vreg_idx_t  insn_vs1_i,
  input  lane_cfg_pkg::vreg_idx_t  insn_vs2_i,
  input  wire                      insn_use_scalar_i,
  input  lane_cfg_pkg::elen_t      insn_scalar_i,
  output logic                     insn_ack_o,
  // Register inspection
  input  lane_cfg_pkg::vreg_idx_t  rd_vreg_i,
  input  lane_cfg_pkg::word_idx_t  rd_word_i,
  output lane_cfg_pkg::elen_t      rd_data_o
);

  opq_if    seq_opq ();
  opq_if    alu_opq ();
  vrf_rd_if vrf_rd ();
  vrf_wr_if vrf_wr ();
  logic     alu_done;

  lane_sequencer i_lane_sequencer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_req_i        (insn_req_i),
    .insn_op_i         (insn_op_i),
    .insn_vew_i        (insn_vew_i),
    .insn_vd_i         (insn_vd_i),
    .insn_vs1_i        (insn_vs1_i),
    .insn_vs2_i        (insn_vs2_i),
    .insn_use_scalar_i (insn_use_scalar_i),
    .insn_scalar_i     (insn_scalar_i),
    .alu_done_i        (alu_done),
    .insn_ack_o        (insn_ack_o),
    .rd                (vrf_rd),
    .opq               (seq_opq)
  );

  vector_regfile i_vrf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_vreg_i (rd_vreg_i),
    .rd_word_i (rd_word_i),
    .rd_data_o (rd_data_o),
    .rd        (vrf_rd),
    .wr        (vrf_wr)
  );

  operand_queue i_operand_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in     (seq_opq),
    .out    (alu_opq)
  );

  vector_alu i_vector_alu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .opq        (alu_opq),
    .wr         (vrf_wr),
    .alu_done_o (alu_done)
  );

endmodule

`default_nettype wire

// ==== logic/lane_cfg_pkg.sv ====
// Lane datapath configuration
`default_nettype none

package lane_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Width of one datapath word
  localparam int ElenWidth = 64;

  // Register file geometry seen by this lane
  localparam int NrVRegs = 32;
  localparam int NrWords = 4;

  // One bank per word index of a register
  localparam int NrBanks = 4;

  // Entries between sequencer and ALU
  localparam int QueueDepth = 4;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [ElenWidth-1:0]        elen_t;
  typedef logic [$clog2(NrVRegs)-1:0]  vreg_idx_t;
  typedef logic [$clog2(NrWords)-1:0]  word_idx_t;

endpackage

`default_nettype wire

// ==== logic/lane_ifs.sv ====
// Lane internal interfaces
`default_nettype none

// Operand pairs with their context
interface opq_if;
  logic                    valid;
  logic                    ready;
  lane_cfg_pkg::elen_t     opnd_a;
  lane_cfg_pkg::elen_t     opnd_b;
  lane_op_pkg::alu_op_e    op;
  lane_op_pkg::vew_e       vew;
  lane_cfg_pkg::vreg_idx_t vd;
  lane_cfg_pkg::word_idx_t word;
  logic                    last;

  modport producer (output valid, opnd_a, opnd_b, op, vew, vd, word, last, input ready);
  modport consumer (input valid, opnd_a, opnd_b, op, vew, vd, word, last, output ready);
endinterface

// Operand reads, data one cycle after rd_en
interface vrf_rd_if;
  logic                    rd_en;
  lane_cfg_pkg::vreg_idx_t vreg_a;
  lane_cfg_pkg::vreg_idx_t vreg_b;
  lane_cfg_pkg::word_idx_t word;
  lane_cfg_pkg::elen_t     data_a;
  lane_cfg_pkg::elen_t     data_b;

  modport requester (output rd_en, vreg_a, vreg_b, word, input data_a, data_b);
  modport regfile (input rd_en, vreg_a, vreg_b, word, output data_a, data_b);
endinterface

// Result write-back
interface vrf_wr_if;
  logic                    wr_en;
  lane_cfg_pkg::vreg_idx_t vreg;
  lane_cfg_pkg::word_idx_t word;
  lane_cfg_pkg::elen_t     data;

  modport writer (output wr_en, vreg, word, data);
  modport regfile (input wr_en, vreg, word, data);
endinterface

`default_nettype wire

// ==== logic/lane_op_pkg.sv ====
// Vector instruction encoding
`default_nettype none

package lane_op_pkg;

  // Element-wise ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_MV
  } alu_op_e;

  // Element width inside a 64-bit word
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

endpackage

`default_nettype wire

// ==== logic/lane_sequencer.sv ====
// Lane instruction sequencer
`default_nettype none

module lane_sequencer (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire                      insn_req_i,
  input  lane_op_pkg::alu_op_e     insn_op_i,
  input  lane_op_pkg::vew_e        insn_vew_i,
  input  lane_cfg_pkg::vreg_idx_t  insn_vd_i,
  input  lane_cfg_pkg::vreg_idx_t  insn_vs1_i,
  input  lane_cfg_pkg::vreg_idx_t  insn_vs2_i,
  input  wire                      insn_use_scalar_i,
  input  lane_cfg_pkg::elen_t      insn_scalar_i,
  input  wire                      alu_done_i,
  output logic                     insn_ack_o,
  vrf_rd_if.requester              rd,
  opq_if.producer                  opq
);

  typedef enum logic [1:0] {IDLE, ISSUE, DRAIN, ACK} state_e;

  state_e                  state_q, state_d;
  lane_cfg_pkg::word_idx_t word_q;
  logic                    rd_pend_q;
  lane_cfg_pkg::word_idx_t rd_word_q;
  lane_cfg_pkg::elen_t     scalar_rep;

  // Latched instruction
  lane_op_pkg::alu_op_e    op_q;
  lane_op_pkg::vew_e       vew_q;
  lane_cfg_pkg::vreg_idx_t vd_q, vs1_q, vs2_q;
  logic                    use_scalar_q;
  lane_cfg_pkg::elen_t     scalar_q;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:  if (insn_req_i) state_d = ISSUE;
      ISSUE: if (rd.rd_en && word_q == lane_cfg_pkg::word_idx_t'(lane_cfg_pkg::NrWords - 1))
               state_d = DRAIN;
      DRAIN: if (alu_done_i) state_d = ACK;
      ACK:   if (!insn_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      word_q    <= '0;
      rd_pend_q <= 1'b0;
      rd_word_q <= '0;
    end else begin
      state_q   <= state_d;
      rd_pend_q <= rd.rd_en;
      rd_word_q <= word_q;
      if (state_q == IDLE) word_q <= '0;
      else if (rd.rd_en) word_q <= word_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && insn_req_i) begin
      op_q         <= insn_op_i;
      vew_q        <= insn_vew_i;
      vd_q         <= insn_vd_i;
      vs1_q        <= insn_vs1_i;
      vs2_q        <= insn_vs2_i;
      use_scalar_q <= insn_use_scalar_i;
      scalar_q     <= insn_scalar_i;
    end
  end

  assign insn_ack_o = (state_q == ACK);

  // Reads only while the queue keeps room for the word in flight
  assign rd.rd_en  = (state_q == ISSUE) && opq.ready;
  assign rd.vreg_a = vs1_q;
  assign rd.vreg_b = vs2_q;
  assign rd.word   = word_q;

  ////////////////////////////////////////////////////////////
  // Operand push
  ////////////////////////////////////////////////////////////

  // Low element of the scalar repeated over the word
  always_comb begin
    case (vew_q)
      lane_op_pkg::EW8:  scalar_rep = {8{scalar_q[7:0]}};
      lane_op_pkg::EW16: scalar_rep = {4{scalar_q[15:0]}};
      lane_op_pkg::EW32: scalar_rep = {2{scalar_q[31:0]}};
      default:           scalar_rep = scalar_q;
    endcase
  end

  assign opq.valid  = rd_pend_q;
  assign opq.opnd_a = use_scalar_q ? scalar_rep : rd.data_a;
  assign opq.opnd_b = rd.data_b;
  assign opq.op     = op_q;
  assign opq.vew    = vew_q;
  assign opq.vd     = vd_q;
  assign opq.word   = rd_word_q;
  assign opq.last   = (rd_word_q == lane_cfg_pkg::word_idx_t'(lane_cfg_pkg::NrWords - 1));

endmodule

`default_nettype wire

// ==== logic/operand_queue.sv ====
// Operand pair FIFO
`default_nettype none

module operand_queue (
  input  wire      clk_i,
  input  wire      rst_ni,
  opq_if.consumer  in,
  opq_if.producer  out
);

  logic [$clog2(lane_cfg_pkg::QueueDepth)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(lane_cfg_pkg::QueueDepth+1)-1:0] count_q;
  logic                                          push, pop;

  // Entry storage
  lane_cfg_pkg::elen_t     opnd_a_q [lane_cfg_pkg::QueueDepth];
  lane_cfg_pkg::elen_t     opnd_b_q [lane_cfg_pkg::QueueDepth];
  lane_op_pkg::alu_op_e    op_q     [lane_cfg_pkg::QueueDepth];
  lane_op_pkg::vew_e       vew_q    [lane_cfg_pkg::QueueDepth];
  lane_cfg_pkg::vreg_idx_t vd_q     [lane_cfg_pkg::QueueDepth];
  lane_cfg_pkg::word_idx_t word_q   [lane_cfg_pkg::QueueDepth];
  logic                    last_q   [lane_cfg_pkg::QueueDepth];

  // Two free slots needed as one is held for the read in flight
  assign in.ready = (int'(count_q) + 2 <= lane_cfg_pkg::QueueDepth);

  // The in-flight word was granted its slot when its read went out
  assign push = in.valid;
  assign pop  = out.valid && out.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == lane_cfg_pkg::QueueDepth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == lane_cfg_pkg::QueueDepth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      opnd_a_q[wr_ptr_q] <= in.opnd_a;
      opnd_b_q[wr_ptr_q] <= in.opnd_b;
      op_q[wr_ptr_q]     <= in.op;
      vew_q[wr_ptr_q]    <= in.vew;
      vd_q[wr_ptr_q]     <= in.vd;
      word_q[wr_ptr_q]   <= in.word;
      last_q[wr_ptr_q]   <= in.last;
    end
  end

  assign out.valid  = (count_q != '0);
  assign out.opnd_a = opnd_a_q[rd_ptr_q];
  assign out.opnd_b = opnd_b_q[rd_ptr_q];
  assign out.op     = op_q[rd_ptr_q];
  assign out.vew    = vew_q[rd_ptr_q];
  assign out.vd     = vd_q[rd_ptr_q];
  assign out.word   = word_q[rd_ptr_q];
  assign out.last   = last_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== logic/vector_alu.sv ====
// Element-wise vector ALU
`default_nettype none

module vector_alu (
  input  wire        clk_i,
  input  wire        rst_ni,
  opq_if.consumer    opq,
  vrf_wr_if.writer   wr,
  output logic       alu_done_o
);

  lane_cfg_pkg::elen_t     result;
  lane_cfg_pkg::elen_t     data_q;
  lane_cfg_pkg::vreg_idx_t vreg_q;
  lane_cfg_pkg::word_idx_t word_q;
  logic                    wr_en_q, done_q, pop;

  // b + a or b - a (vs2 op vs1), carries stay inside each element
  function automatic lane_cfg_pkg::elen_t add_sub(lane_cfg_pkg::elen_t a,
                                                  lane_cfg_pkg::elen_t b,
                                                  logic sub, lane_op_pkg::vew_e vew);
    lane_cfg_pkg::elen_t res;
    res = '0;
    case (vew)
      lane_op_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          res[8*i +: 8] = sub ? b[8*i +: 8] - a[8*i +: 8] : b[8*i +: 8] + a[8*i +: 8];
        end
      end
      lane_op_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          res[16*i +: 16] = sub ? b[16*i +: 16] - a[16*i +: 16] : b[16*i +: 16] + a[16*i +: 16];
        end
      end
      lane_op_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          res[32*i +: 32] = sub ? b[32*i +: 32] - a[32*i +: 32] : b[32*i +: 32] + a[32*i +: 32];
        end
      end
      default: res = sub ? b - a : b + a;
    endcase
    return res;
  endfunction

  assign opq.ready = 1'b1;
  assign pop       = opq.valid && opq.ready;

  always_comb begin
    case (opq.op)
      lane_op_pkg::ALU_ADD: result = add_sub(opq.opnd_a, opq.opnd_b, 1'b0, opq.vew);
      lane_op_pkg::ALU_SUB: result = add_sub(opq.opnd_a, opq.opnd_b, 1'b1, opq.vew);
      lane_op_pkg::ALU_AND: result = opq.opnd_a & opq.opnd_b;
      lane_op_pkg::ALU_OR:  result = opq.opnd_a | opq.opnd_b;
      lane_op_pkg::ALU_XOR: result = opq.opnd_a ^ opq.opnd_b;
      default:              result = opq.opnd_a;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Write-back stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_en_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      wr_en_q <= pop;
      done_q  <= pop && opq.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      data_q <= result;
      vreg_q <= opq.vd;
      word_q <= opq.word;
    end
  end

  assign wr.wr_en   = wr_en_q;
  assign wr.vreg    = vreg_q;
  assign wr.word    = word_q;
  assign wr.data    = data_q;
  // Pulses together with the write of the last word
  assign alu_done_o = done_q;

endmodule

`default_nettype wire

// ==== logic/vector_regfile.sv ====
// Banked vector register file
`default_nettype none

module vector_regfile (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  lane_cfg_pkg::vreg_idx_t  rd_vreg_i,
  input  lane_cfg_pkg::word_idx_t  rd_word_i,
  output lane_cfg_pkg::elen_t      rd_data_o,
  vrf_rd_if.regfile                rd,
  vrf_wr_if.regfile                wr
);

  lane_cfg_pkg::elen_t bank_a   [lane_cfg_pkg::NrBanks];
  lane_cfg_pkg::elen_t bank_b   [lane_cfg_pkg::NrBanks];
  lane_cfg_pkg::elen_t bank_dbg [lane_cfg_pkg::NrBanks];
  lane_cfg_pkg::elen_t data_a_q, data_b_q;

  // Word w of every register lives in bank w
  for (genvar b = 0; b < lane_cfg_pkg::NrBanks; b++) begin : gen_bank
    lane_cfg_pkg::elen_t mem_q [lane_cfg_pkg::NrVRegs];

    always_ff @(posedge clk_i) begin
      if (wr.wr_en && wr.word == lane_cfg_pkg::word_idx_t'(b)) begin
        mem_q[wr.vreg] <= wr.data;
      end
    end

    assign bank_a[b]   = mem_q[rd.vreg_a];
    assign bank_b[b]   = mem_q[rd.vreg_b];
    assign bank_dbg[b] = mem_q[rd_vreg_i];
  end

  // Operand reads see the value before a same-cycle write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_a_q <= '0;
      data_b_q <= '0;
    end else if (rd.rd_en) begin
      data_a_q <= bank_a[rd.word];
      data_b_q <= bank_b[rd.word];
    end
  end

  assign rd.data_a = data_a_q;
  assign rd.data_b = data_b_q;
  assign rd_data_o = bank_dbg[rd_word_i];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -f lane.f --top-module tb_lane -o tb_lane_sim --Mdir obj_dir \
  > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_lane_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$SIM_LOG"; then
  exit 1
fi
exit 0

// ==== tb/lane_ref_model.svh ====
// Lane reference model
`ifndef LANE_REF_MODEL_SVH
`define LANE_REF_MODEL_SVH

// Shadow copy of the vector registers
lane_cfg_pkg::elen_t ref_regs [lane_cfg_pkg::NrVRegs][lane_cfg_pkg::NrWords];
bit                  ref_written [lane_cfg_pkg::NrVRegs];
logic [31:0]         lfsr_q = 32'd87525;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
  logic out;
  out    = lfsr_q[0];
  lfsr_q = lfsr_q >> 1;
  if (out) lfsr_q = lfsr_q ^ 32'h8020_0003;
  return out;
endfunction

function automatic lane_cfg_pkg::elen_t draw_word();
  lane_cfg_pkg::elen_t w;
  for (int i = 0; i < lane_cfg_pkg::ElenWidth; i++) w[i] = lfsr_bit();
  return w;
endfunction

function automatic int elem_bits(lane_op_pkg::vew_e vew);
  return 8 << int'(vew);
endfunction

function automatic lane_cfg_pkg::elen_t elem_mask(int bits);
  return (bits >= lane_cfg_pkg::ElenWidth) ? '1 : ((64'd1 << bits) - 64'd1);
endfunction

// Low element copied into every element slot
function automatic lane_cfg_pkg::elen_t splat(lane_cfg_pkg::elen_t scalar,
                                              lane_op_pkg::vew_e vew);
  int                  bits;
  lane_cfg_pkg::elen_t res;
  bits = elem_bits(vew);
  res  = '0;
  for (int pos = 0; pos < lane_cfg_pkg::ElenWidth; pos += bits) begin
    res = res | ((scalar & elem_mask(bits)) << pos);
  end
  return res;
endfunction

// One element at a time, vs2 op vs1, result cut to the element
function automatic lane_cfg_pkg::elen_t expected_word(lane_op_pkg::alu_op_e op,
                                                      lane_op_pkg::vew_e vew,
                                                      lane_cfg_pkg::elen_t a,
                                                      lane_cfg_pkg::elen_t b);
  int                  bits;
  lane_cfg_pkg::elen_t mask, ea, eb, er, res;
  bits = elem_bits(vew);
  mask = elem_mask(bits);
  res  = '0;
  for (int pos = 0; pos < lane_cfg_pkg::ElenWidth; pos += bits) begin
    ea = (a >> pos) & mask;
    eb = (b >> pos) & mask;
    case (op)
      lane_op_pkg::ALU_ADD: er = eb + ea;
      lane_op_pkg::ALU_SUB: er = eb - ea;
      lane_op_pkg::ALU_AND: er = ea & eb;
      lane_op_pkg::ALU_OR:  er = ea | eb;
      lane_op_pkg::ALU_XOR: er = ea ^ eb;
      default:              er = ea;
    endcase
    res = res | ((er & mask) << pos);
  end
  return res;
endfunction

// Sources are read in full before vd changes
function automatic void ref_apply(lane_op_pkg::alu_op_e op, lane_op_pkg::vew_e vew,
                                  lane_cfg_pkg::vreg_idx_t vd,
                                  lane_cfg_pkg::vreg_idx_t vs1,
                                  lane_cfg_pkg::vreg_idx_t vs2,
                                  logic use_scalar, lane_cfg_pkg::elen_t scalar);
  lane_cfg_pkg::elen_t new_words [lane_cfg_pkg::NrWords];
  lane_cfg_pkg::elen_t a;
  for (int w = 0; w < lane_cfg_pkg::NrWords; w++) begin
    a = use_scalar ? splat(scalar, vew) : ref_regs[vs1][w];
    new_words[w] = expected_word(op, vew, a, ref_regs[vs2][w]);
  end
  for (int w = 0; w < lane_cfg_pkg::NrWords; w++) ref_regs[vd][w] = new_words[w];
  ref_written[vd] = 1'b1;
endfunction

`endif

// ==== tb/tb_lane.sv ====
// Vector lane testbench
`default_nettype none

module tb_lane;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ResetCycles   = 10;
  localparam int CyclesPerTest = 40;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    insn_req_i;
  lane_op_pkg::alu_op_e    insn_op_i;
  lane_op_pkg::vew_e       insn_vew_i;
  lane_cfg_pkg::vreg_idx_t insn_vd_i;
  lane_cfg_pkg::vreg_idx_t insn_vs1_i;
  lane_cfg_pkg::vreg_idx_t insn_vs2_i;
  logic                    insn_use_scalar_i;
  lane_cfg_pkg::elen_t     insn_scalar_i;
  logic                    insn_ack_o;
  lane_cfg_pkg::vreg_idx_t rd_vreg_i;
  lane_cfg_pkg::word_idx_t rd_word_i;
  lane_cfg_pkg::elen_t     rd_data_o;

  // Stimulus table, one row per instruction
  string                   tab_name [$];
  lane_op_pkg::alu_op_e    tab_op [$];
  lane_op_pkg::vew_e       tab_vew [$];
  lane_cfg_pkg::vreg_idx_t tab_vd [$];
  lane_cfg_pkg::vreg_idx_t tab_vs1 [$];
  lane_cfg_pkg::vreg_idx_t tab_vs2 [$];
  logic                    tab_use_scalar [$];
  lane_cfg_pkg::elen_t     tab_scalar [$];

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  `include "lane_ref_model.svh"

  lane DUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_req_i        (insn_req_i),
    .insn_op_i         (insn_op_i),
    .insn_vew_i        (insn_vew_i),
    .insn_vd_i         (insn_vd_i),
    .insn_vs1_i        (insn_vs1_i),
    .insn_vs2_i        (insn_vs2_i),
    .insn_use_scalar_i (insn_use_scalar_i),
    .insn_scalar_i     (insn_scalar_i),
    .insn_ack_o        (insn_ack_o),
    .rd_vreg_i         (rd_vreg_i),
    .rd_word_i         (rd_word_i),
    .rd_data_o         (rd_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input int word,
                            input lane_cfg_pkg::elen_t expected,
                            input lane_cfg_pkg::elen_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s word %0d: expected %h actual %h", name, word, expected, actual);
    end
  endtask

  task automatic check_ack(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s insn_ack_o: expected %b actual %b", name, expected, actual);
    end
  endtask

  task automatic add_entry(input string name, input lane_op_pkg::alu_op_e op,
                           input lane_op_pkg::vew_e vew, input int vd, input int vs1,
                           input int vs2, input logic use_scalar,
                           input lane_cfg_pkg::elen_t scalar);
    tab_name.push_back(name);
    tab_op.push_back(op);
    tab_vew.push_back(vew);
    tab_vd.push_back(lane_cfg_pkg::vreg_idx_t'(vd));
    tab_vs1.push_back(lane_cfg_pkg::vreg_idx_t'(vs1));
    tab_vs2.push_back(lane_cfg_pkg::vreg_idx_t'(vs2));
    tab_use_scalar.push_back(use_scalar);
    tab_scalar.push_back(scalar);
  endtask

  // A zero scalar is replaced by a random draw
  task automatic fill_table();
    add_entry("mv_ew8_s", lane_op_pkg::ALU_MV, lane_op_pkg::EW8, 1, 0, 0, 1'b1, '0);
    add_entry("mv_ew16_s", lane_op_pkg::ALU_MV, lane_op_pkg::EW16, 2, 0, 0, 1'b1, '0);
    add_entry("mv_ew32_s", lane_op_pkg::ALU_MV, lane_op_pkg::EW32, 3, 0, 0, 1'b1, '0);
    add_entry("mv_ew64_s", lane_op_pkg::ALU_MV, lane_op_pkg::EW64, 4, 0, 0, 1'b1, '0);
    add_entry("mv_ones", lane_op_pkg::ALU_MV, lane_op_pkg::EW64, 5, 0, 0, 1'b1, '1);
    add_entry("mv_one8", lane_op_pkg::ALU_MV, lane_op_pkg::EW8, 6, 0, 0, 1'b1, 64'h1);
    add_entry("add_ew8_wrap", lane_op_pkg::ALU_ADD, lane_op_pkg::EW8, 7, 6, 5, 1'b0, '0);
    add_entry("add_ew16_wrap", lane_op_pkg::ALU_ADD, lane_op_pkg::EW16, 8, 6, 5, 1'b0, '0);
    add_entry("add_ew32", lane_op_pkg::ALU_ADD, lane_op_pkg::EW32, 9, 1, 3, 1'b0, '0);
    add_entry("add_ew64", lane_op_pkg::ALU_ADD, lane_op_pkg::EW64, 10, 5, 6, 1'b0, '0);
    add_entry("sub_ew8", lane_op_pkg::ALU_SUB, lane_op_pkg::EW8, 11, 5, 6, 1'b0, '0);
    add_entry("sub_ew16", lane_op_pkg::ALU_SUB, lane_op_pkg::EW16, 12, 2, 1, 1'b0, '0);
    add_entry("sub_ew32", lane_op_pkg::ALU_SUB, lane_op_pkg::EW32, 13, 5, 4, 1'b0, '0);
    add_entry("sub_ew64", lane_op_pkg::ALU_SUB, lane_op_pkg::EW64, 14, 5, 6, 1'b0, '0);
    add_entry("and_regs", lane_op_pkg::ALU_AND, lane_op_pkg::EW64, 15, 1, 2, 1'b0, '0);
    add_entry("or_regs", lane_op_pkg::ALU_OR, lane_op_pkg::EW8, 16, 3, 4, 1'b0, '0);
    add_entry("xor_regs", lane_op_pkg::ALU_XOR, lane_op_pkg::EW32, 17, 1, 4, 1'b0, '0);
    add_entry("add_scalar16", lane_op_pkg::ALU_ADD, lane_op_pkg::EW16, 18, 0, 4, 1'b1, '0);
    add_entry("add_in_place", lane_op_pkg::ALU_ADD, lane_op_pkg::EW8, 1, 1, 2, 1'b0, '0);
    add_entry("xor_in_place", lane_op_pkg::ALU_XOR, lane_op_pkg::EW64, 3, 3, 4, 1'b0, '0);
    add_entry("mv_copy", lane_op_pkg::ALU_MV, lane_op_pkg::EW32, 19, 18, 0, 1'b0, '0);
  endtask

  // Debug port read, sampled mid-cycle
  task automatic read_word(input lane_cfg_pkg::vreg_idx_t vreg, input int word,
                           output lane_cfg_pkg::elen_t data);
    @(posedge clk_i);
    rd_vreg_i <= vreg;
    rd_word_i <= lane_cfg_pkg::word_idx_t'(word);
    @(negedge clk_i);
    data = rd_data_o;
  endtask

  ////////////////////////////////////////////////////////////
  // Instruction run with the four-phase handshake
  ////////////////////////////////////////////////////////////

  task automatic run_test(input int idx);
    int                  errors_before;
    lane_cfg_pkg::elen_t scalar;
    lane_cfg_pkg::elen_t got;
    string               name;
    errors_before = error_count;
    name          = tab_name[idx];
    scalar        = tab_scalar[idx];
    if (scalar == '0) scalar = draw_word();
    ref_apply(tab_op[idx], tab_vew[idx], tab_vd[idx], tab_vs1[idx], tab_vs2[idx],
              tab_use_scalar[idx], scalar);

    @(posedge clk_i);
    insn_op_i         <= tab_op[idx];
    insn_vew_i        <= tab_vew[idx];
    insn_vd_i         <= tab_vd[idx];
    insn_vs1_i        <= tab_vs1[idx];
    insn_vs2_i        <= tab_vs2[idx];
    insn_use_scalar_i <= tab_use_scalar[idx];
    insn_scalar_i     <= scalar;
    insn_req_i        <= 1'b1;
    // Watch the last word so it can be checked the moment ack rises
    rd_vreg_i         <= tab_vd[idx];
    rd_word_i         <= lane_cfg_pkg::word_idx_t'(lane_cfg_pkg::NrWords - 1);

    @(negedge clk_i);
    while (insn_ack_o !== 1'b1) @(negedge clk_i);
    check_word({name, " at ack"}, lane_cfg_pkg::NrWords - 1,
               ref_regs[tab_vd[idx]][lane_cfg_pkg::NrWords - 1], rd_data_o);

    for (int w = 0; w < lane_cfg_pkg::NrWords; w++) begin
      read_word(tab_vd[idx], w, got);
      check_word(name, w, ref_regs[tab_vd[idx]][w], got);
    end
    check_ack({name, " ack held"}, 1'b1, insn_ack_o);

    @(posedge clk_i);
    insn_req_i <= 1'b0;
    @(negedge clk_i);
    check_ack({name, " ack before fall"}, 1'b1, insn_ack_o);
    @(negedge clk_i);
    check_ack({name, " ack fall"}, 1'b0, insn_ack_o);

    if (error_count == errors_before) $display("test %-16s pass", name);
    else $display("test %-16s fail, %0d errors", name, error_count - errors_before);
  endtask

  // Every register the table wrote, after the whole table
  task automatic check_all_regs();
    int                  errors_before;
    lane_cfg_pkg::elen_t got;
    errors_before = error_count;
    for (int r = 0; r < lane_cfg_pkg::NrVRegs; r++) begin
      if (ref_written[r]) begin
        for (int w = 0; w < lane_cfg_pkg::NrWords; w++) begin
          read_word(lane_cfg_pkg::vreg_idx_t'(r), w, got);
          check_word($sformatf("final v%0d", r), w, ref_regs[r][w], got);
        end
      end
    end
    if (error_count == errors_before) $display("test %-16s pass", "final_sweep");
    else $display("test %-16s fail, %0d errors", "final_sweep", error_count - errors_before);
  endtask

  initial begin
    rst_ni            <= 1'b0;
    insn_req_i        <= 1'b0;
    insn_op_i         <= lane_op_pkg::ALU_ADD;
    insn_vew_i        <= lane_op_pkg::EW8;
    insn_vd_i         <= '0;
    insn_vs1_i        <= '0;
    insn_vs2_i        <= '0;
    insn_use_scalar_i <= 1'b0;
    insn_scalar_i     <= '0;
    rd_vreg_i         <= '0;
    rd_word_i         <= '0;
    fill_table();
    cycle_limit = tab_name.size() * CyclesPerTest + ResetCycles;

    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_ack("after_reset", 1'b0, insn_ack_o);

    for (int i = 0; i < tab_name.size(); i++) run_test(i);
    check_all_regs();

    $display("Summary: %0d tests, %0d checks, %0d errors",
             tab_name.size() + 1, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
